// File: Makefile
# Verilator flow for the execute datapath

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module datapath_top
	verilator --lint-only --timing -f vlog.f --top-module tb_datapath

sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_datapath \
		-Mdir obj_dir -o sim_tb
	-./obj_dir/sim_tb 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire dp_pkg::word_t   val_a,
    input  wire dp_pkg::word_t   val_b,
    input  wire dp_pkg::alu_op_e alu_op,
    output dp_pkg::word_t        alu_out,
    output dp_pkg::word_t        flags
);

    logic [31:0] add_x;
    logic [31:0] add_y;
    logic        add_cin;
    logic [32:0] add_sum;
    logic        is_arith;
    logic        carry;
    logic        overflow;

    // shared adder, subtraction as x + ~y + 1
    always_comb begin
        add_x   = val_a;
        add_y   = val_b;
        add_cin = 1'b0;
        case (alu_op)
            dp_pkg::ALU_SUB: begin
                add_y   = ~val_b;
                add_cin = 1'b1;
            end
            dp_pkg::ALU_RSB: begin
                add_x   = val_b;
                add_y   = ~val_a;
                add_cin = 1'b1;
            end
            default: begin
                add_cin = 1'b0;
            end
        endcase
    end

    assign add_sum = {1'b0, add_x} + {1'b0, add_y} + {32'b0, add_cin};

    assign is_arith = (alu_op == dp_pkg::ALU_ADD) || (alu_op == dp_pkg::ALU_SUB) ||
                      (alu_op == dp_pkg::ALU_RSB);

    // carry out doubles as no-borrow on subtraction
    assign carry    = is_arith && add_sum[32];
    assign overflow = is_arith && (add_x[31] == add_y[31]) && (add_sum[31] != add_x[31]);

    always_comb begin
        case (alu_op)
            dp_pkg::ALU_AND: alu_out = val_a & val_b;
            dp_pkg::ALU_ORR: alu_out = val_a | val_b;
            dp_pkg::ALU_EOR: alu_out = val_a ^ val_b;
            dp_pkg::ALU_MOV: alu_out = val_b;
            dp_pkg::ALU_MVN: alu_out = ~val_b;
            default:         alu_out = add_sum[31:0];
        endcase
    end

    // nzcv in the top nibble, everything else zero
    always_comb begin
        flags                = '0;
        flags[dp_pkg::FLAG_N] = alu_out[31];
        flags[dp_pkg::FLAG_Z] = (alu_out == '0);
        flags[dp_pkg::FLAG_C] = carry;
        flags[dp_pkg::FLAG_V] = overflow;
    end

endmodule : alu

`default_nettype wire

// File: barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter (
    input  wire dp_pkg::word_t     shift_in,
    input  wire dp_pkg::shift_op_e shift_op,
    input  wire dp_pkg::word_t     shift_amt,
    output dp_pkg::word_t          shift_out
);

    logic [4:0]  amt;
    logic [63:0] rot_wide;
    logic [31:0] lsl_val;
    logic [31:0] lsr_val;
    logic [31:0] asr_val;
    logic [31:0] ror_val;

    // only the low five bits count, larger amounts wrap
    assign amt = shift_amt[4:0];

    assign lsl_val = shift_in << amt;
    assign lsr_val = shift_in >> amt;

    // sign bit fills from the left
    assign asr_val = $signed(shift_in) >>> amt;

    // rotate via a doubled word
    // amount zero leaves the input as is
    assign rot_wide = {shift_in, shift_in} >> amt;
    assign ror_val  = rot_wide[31:0];

    always_comb begin
        case (shift_op)
            dp_pkg::SH_LSL: begin
                shift_out = lsl_val;
            end
            dp_pkg::SH_LSR: begin
                shift_out = lsr_val;
            end
            dp_pkg::SH_ASR: begin
                shift_out = asr_val;
            end
            dp_pkg::SH_ROR: begin
                shift_out = ror_val;
            end
            default: begin
                shift_out = shift_in;
            end
        endcase
    end

endmodule : barrel_shifter

`default_nettype wire

// File: datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter int NUM_REGS = 16
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire dp_pkg::word_t      ram_data,
    input  wire logic               fwd_ram,
    input  wire dp_pkg::reg_addr_t  w_addr1,
    input  wire logic               w_en1,
    input  wire dp_pkg::reg_addr_t  w_addr2,
    input  wire logic               w_en2,
    input  wire dp_pkg::reg_addr_t  w_addr3,
    input  wire logic               w_en3,
    input  wire dp_pkg::word_t      w_data3,
    input  wire dp_pkg::reg_addr_t  a_addr,
    input  wire dp_pkg::reg_addr_t  b_addr,
    input  wire dp_pkg::reg_addr_t  shift_addr,
    input  wire dp_pkg::reg_addr_t  str_addr,
    input  wire dp_pkg::word_t      pc,
    input  wire dp_pkg::fwd_sel_e   sel_a_in,
    input  wire dp_pkg::fwd_sel_e   sel_b_in,
    input  wire dp_pkg::fwd_sel_e   sel_shift_in,
    input  wire logic               en_a,
    input  wire logic               en_b,
    input  wire logic               en_s,
    input  wire dp_pkg::word_t      shift_imm,
    input  wire logic               sel_shift,
    input  wire dp_pkg::shift_op_e  shift_op,
    input  wire logic               sel_a,
    input  wire logic               sel_b,
    input  wire logic               sel_post_shift,
    input  wire dp_pkg::word_t      imm_data,
    input  wire dp_pkg::alu_op_e    alu_op,
    input  wire logic               en_status,
    output dp_pkg::word_t           datapath_out,
    output dp_pkg::word_t           status_out,
    output dp_pkg::word_t           str_data
);

    rf_read_if rf_rd ();

    dp_pkg::word_t a_in, b_in, s_fwd, s_next;
    dp_pkg::word_t a_reg, b_reg, s_reg, status_reg;
    dp_pkg::word_t shift_out, val_a, val_b, val_b_in;
    dp_pkg::word_t alu_out, alu_flags, w_data1;

    assign rf_rd.a_addr     = a_addr;
    assign rf_rd.b_addr     = b_addr;
    assign rf_rd.shift_addr = shift_addr;
    assign rf_rd.str_addr   = str_addr;
    assign str_data         = rf_rd.str_data;

    regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .w_addr1 (w_addr1),
        .w_en1   (w_en1),
        .w_data1 (w_data1),
        .w_addr2 (w_addr2),
        .w_en2   (w_en2),
        .w_data2 (val_b_in),
        .w_addr3 (w_addr3),
        .w_en3   (w_en3),
        .w_data3 (w_data3),
        .rd      (rf_rd.responder)
    );

    barrel_shifter u_shifter (
        .shift_in  (b_reg),
        .shift_op  (shift_op),
        .shift_amt (s_reg),
        .shift_out (shift_out)
    );

    alu u_alu (
        .val_a   (val_a),
        .val_b   (val_b),
        .alu_op  (alu_op),
        .alu_out (alu_out),
        .flags   (alu_flags)
    );

    // operand selection and write-back values
    assign val_a        = sel_a ? '0 : a_reg;
    assign val_b_in     = sel_b ? imm_data : shift_out;
    assign val_b        = sel_post_shift ? b_reg : val_b_in;
    assign w_data1      = fwd_ram ? ram_data : alu_out;
    assign s_next       = sel_shift ? s_fwd : shift_imm;
    assign datapath_out = alu_out;
    assign status_out   = status_reg;

    // forwarding muxes, reserved code falls back to the register file
    always_comb begin
        case (sel_a_in)
            dp_pkg::FWD_ALU: a_in = alu_out;
            dp_pkg::FWD_ALT: a_in = pc;
            default:         a_in = rf_rd.a_data;
        endcase
        case (sel_b_in)
            dp_pkg::FWD_ALU: b_in = alu_out;
            dp_pkg::FWD_ALT: b_in = val_b;
            default:         b_in = rf_rd.b_data;
        endcase
        case (sel_shift_in)
            dp_pkg::FWD_ALU: s_fwd = alu_out;
            dp_pkg::FWD_ALT: s_fwd = '0;
            default:         s_fwd = rf_rd.shift_data;
        endcase
    end

    // operand and status registers, each holds unless enabled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_reg      <= '0;
            b_reg      <= '0;
            s_reg      <= '0;
            status_reg <= '0;
        end else begin
            if (en_a) begin
                a_reg <= a_in;
            end
            if (en_b) begin
                b_reg <= b_in;
            end
            if (en_s) begin
                s_reg <= s_next;
            end
            if (en_status) begin
                status_reg <= alu_flags;
            end
        end
    end

    // the s mux only matters when the register operand is taken
    a_no_rsvd_fwd: assert property (@(posedge clk) disable iff (!arst_n)
        !((en_a && sel_a_in == dp_pkg::FWD_RSVD) ||
          (en_b && sel_b_in == dp_pkg::FWD_RSVD) ||
          (en_s && sel_shift && sel_shift_in == dp_pkg::FWD_RSVD)))
        else $error("datapath: reserved forwarding select with register enable high");

endmodule : datapath

`default_nettype wire

// File: datapath_top.sv
`timescale 1ns/1ps
`default_nettype none

module datapath_top #(
    parameter int NUM_REGS = 16
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire dp_pkg::word_t      ram_data,
    input  wire logic               fwd_ram,
    input  wire dp_pkg::reg_addr_t  w_addr1,
    input  wire logic               w_en1,
    input  wire dp_pkg::reg_addr_t  w_addr2,
    input  wire logic               w_en2,
    input  wire dp_pkg::reg_addr_t  w_addr3,
    input  wire logic               w_en3,
    input  wire dp_pkg::word_t      w_data3,
    input  wire dp_pkg::reg_addr_t  a_addr,
    input  wire dp_pkg::reg_addr_t  b_addr,
    input  wire dp_pkg::reg_addr_t  shift_addr,
    input  wire dp_pkg::reg_addr_t  str_addr,
    input  wire dp_pkg::word_t      pc,
    input  wire dp_pkg::fwd_sel_e   sel_a_in,
    input  wire dp_pkg::fwd_sel_e   sel_b_in,
    input  wire dp_pkg::fwd_sel_e   sel_shift_in,
    input  wire logic               en_a,
    input  wire logic               en_b,
    input  wire logic               en_s,
    input  wire dp_pkg::word_t      shift_imm,
    input  wire logic               sel_shift,
    input  wire dp_pkg::shift_op_e  shift_op,
    input  wire logic               sel_a,
    input  wire logic               sel_b,
    input  wire logic               sel_post_shift,
    input  wire dp_pkg::word_t      imm_data,
    input  wire dp_pkg::alu_op_e    alu_op,
    input  wire logic               en_status,
    output dp_pkg::word_t           datapath_out,
    output dp_pkg::word_t           status_out,
    output dp_pkg::word_t           str_data
);

    // register count chosen here and passed down to the register file
    datapath #(
        .NUM_REGS (NUM_REGS)
    ) u_datapath (
        .clk            (clk),
        .arst_n         (arst_n),
        .ram_data       (ram_data),
        .fwd_ram        (fwd_ram),
        .w_addr1        (w_addr1),
        .w_en1          (w_en1),
        .w_addr2        (w_addr2),
        .w_en2          (w_en2),
        .w_addr3        (w_addr3),
        .w_en3          (w_en3),
        .w_data3        (w_data3),
        .a_addr         (a_addr),
        .b_addr         (b_addr),
        .shift_addr     (shift_addr),
        .str_addr       (str_addr),
        .pc             (pc),
        .sel_a_in       (sel_a_in),
        .sel_b_in       (sel_b_in),
        .sel_shift_in   (sel_shift_in),
        .en_a           (en_a),
        .en_b           (en_b),
        .en_s           (en_s),
        .shift_imm      (shift_imm),
        .sel_shift      (sel_shift),
        .shift_op       (shift_op),
        .sel_a          (sel_a),
        .sel_b          (sel_b),
        .sel_post_shift (sel_post_shift),
        .imm_data       (imm_data),
        .alu_op         (alu_op),
        .en_status      (en_status),
        .datapath_out   (datapath_out),
        .status_out     (status_out),
        .str_data       (str_data)
    );

endmodule : datapath_top

`default_nettype wire

// File: dp_pkg.sv
`default_nettype none

package dp_pkg;

    // datapath word and register index
    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // alu operations, mov and mvn act on operand b only
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_ORR = 3'd3,
        ALU_EOR = 3'd4,
        ALU_MOV = 3'd5,
        ALU_MVN = 3'd6,
        ALU_RSB = 3'd7
    } alu_op_e;

    // barrel shifter operations
    typedef enum logic [1:0] {
        SH_LSL = 2'd0,
        SH_LSR = 2'd1,
        SH_ASR = 2'd2,
        SH_ROR = 2'd3
    } shift_op_e;

    // operand register sources
    // alt source is pc for a, post-shift b for b, zero for s
    typedef enum logic [1:0] {
        FWD_RF   = 2'd0,
        FWD_ALU  = 2'd1,
        FWD_RSVD = 2'd2,
        FWD_ALT  = 2'd3
    } fwd_sel_e;

    // nzcv positions in the status word
    localparam int FLAG_N = 31;
    localparam int FLAG_Z = 30;
    localparam int FLAG_C = 29;
    localparam int FLAG_V = 28;

endpackage : dp_pkg

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile #(
    parameter int NUM_REGS = 16
) (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire dp_pkg::reg_addr_t  w_addr1,
    input  wire logic               w_en1,
    input  wire dp_pkg::word_t      w_data1,
    input  wire dp_pkg::reg_addr_t  w_addr2,
    input  wire logic               w_en2,
    input  wire dp_pkg::word_t      w_data2,
    input  wire dp_pkg::reg_addr_t  w_addr3,
    input  wire logic               w_en3,
    input  wire dp_pkg::word_t      w_data3,
    rf_read_if.responder            rd
);

    dp_pkg::word_t regs [NUM_REGS];

    // one flop row per register
    // port 3 beats port 2, port 2 beats port 1
    for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                regs[i] <= '0;
            end else if (w_en3 && w_addr3 == dp_pkg::reg_addr_t'(i)) begin
                regs[i] <= w_data3;
            end else if (w_en2 && w_addr2 == dp_pkg::reg_addr_t'(i)) begin
                regs[i] <= w_data2;
            end else if (w_en1 && w_addr1 == dp_pkg::reg_addr_t'(i)) begin
                regs[i] <= w_data1;
            end
        end
    end

    // four read ports, addresses past the array give zero
    always_comb begin
        rd.a_data     = '0;
        rd.b_data     = '0;
        rd.shift_data = '0;
        rd.str_data   = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (rd.a_addr == dp_pkg::reg_addr_t'(i)) begin
                rd.a_data = regs[i];
            end
            if (rd.b_addr == dp_pkg::reg_addr_t'(i)) begin
                rd.b_data = regs[i];
            end
            if (rd.shift_addr == dp_pkg::reg_addr_t'(i)) begin
                rd.shift_data = regs[i];
            end
            if (rd.str_addr == dp_pkg::reg_addr_t'(i)) begin
                rd.str_data = regs[i];
            end
        end
    end

    // writes beyond a reduced register count would be silently dropped
    a_waddr_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        (!w_en1 || int'(w_addr1) < NUM_REGS) &&
        (!w_en2 || int'(w_addr2) < NUM_REGS) &&
        (!w_en3 || int'(w_addr3) < NUM_REGS))
        else $error("regfile: enabled write address outside the register array");

endmodule : regfile

`default_nettype wire

// File: rf_read_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rf_read_if;

    // read addresses
    dp_pkg::reg_addr_t a_addr;
    dp_pkg::reg_addr_t b_addr;
    dp_pkg::reg_addr_t shift_addr;
    dp_pkg::reg_addr_t str_addr;

    // read data, combinational from the array
    dp_pkg::word_t a_data;
    dp_pkg::word_t b_data;
    dp_pkg::word_t shift_data;
    dp_pkg::word_t str_data;

    modport requester (
        output a_addr, b_addr, shift_addr, str_addr,
        input  a_data, b_data, shift_data, str_data
    );

    modport responder (
        input  a_addr, b_addr, shift_addr, str_addr,
        output a_data, b_data, shift_data, str_data
    );

endinterface : rf_read_if

`default_nettype wire

// File: tb_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_datapath;

    typedef enum logic [2:0] {
        WB_ALU,
        WB_RAM,
        WB_VALB,
        WB_ALL3,
        WB_P21
    } wb_kind_e;

    typedef struct packed {
        logic [31:0]       a;
        logic [31:0]       b;
        logic              rnd;
        dp_pkg::shift_op_e shop;
        logic [4:0]        amt;
        dp_pkg::alu_op_e   op;
        dp_pkg::fwd_sel_e  fwd_a;
        logic              sel_a;
        logic              sel_b;
        logic              post;
        logic              rf_sh;
        wb_kind_e          wb;
    } row_t;

    localparam int NROWS = 23;
    localparam int CYCLES_PER_ROW = 8;
    // reset and the register sweep after it fit inside the margin
    localparam int MAX_CYCLES = NROWS * CYCLES_PER_ROW + 40;

    // a, b, rnd, shift op, amount
    // alu op, fwd into a, sel_a, sel_b, post, shift from rf, write-back kind
    localparam row_t ROWS [NROWS] = '{
        '{32'h7FFFFFFF, 32'h00000001, 1'b0, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_ADD, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALU},
        '{32'hFFFFFFFF, 32'h00000001, 1'b0, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_ADD, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_RAM},
        '{32'h00000000, 32'h00000001, 1'b0, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_SUB, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_VALB},
        '{32'h80000000, 32'h00000001, 1'b0, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_SUB, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALL3},
        '{32'hFFFFFFFF, 32'h00000000, 1'b0, dp_pkg::SH_LSR, 5'd2,
          dp_pkg::ALU_AND, dp_pkg::FWD_RF, 1'b0, 1'b1, 1'b1, 1'b0, WB_P21},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_ORR, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALU},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_EOR, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALU},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_ROR, 5'd9,
          dp_pkg::ALU_MOV, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b1, WB_VALB},
        '{32'h00000000, 32'hFFFFFFFF, 1'b0, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_MVN, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALU},
        '{32'h00000001, 32'h00000000, 1'b0, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_RSB, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALU},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_ADD, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALU},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_SUB, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_RAM},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_RSB, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALU},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_LSL, 5'd4,
          dp_pkg::ALU_MOV, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b0, 1'b0, WB_VALB},
        '{32'h00000000, 32'h80000000, 1'b0, dp_pkg::SH_LSR, 5'd31,
          dp_pkg::ALU_MOV, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b0, 1'b1, WB_ALU},
        '{32'h00000000, 32'h80000000, 1'b0, dp_pkg::SH_ASR, 5'd8,
          dp_pkg::ALU_MOV, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b0, 1'b0, WB_ALU},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_ROR, 5'd0,
          dp_pkg::ALU_MOV, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b0, 1'b1, WB_ALU},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_ROR, 5'd13,
          dp_pkg::ALU_MOV, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b0, 1'b0, WB_ALU},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_ASR, 5'd3,
          dp_pkg::ALU_MOV, dp_pkg::FWD_RF, 1'b0, 1'b0, 1'b0, 1'b1, WB_ALL3},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_LSL, 5'd5,
          dp_pkg::ALU_MOV, dp_pkg::FWD_RF, 1'b0, 1'b1, 1'b0, 1'b0, WB_VALB},
        '{32'h11111111, 32'h22222222, 1'b0, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_ADD, dp_pkg::FWD_ALU, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALU},
        '{32'h11111111, 32'h00000100, 1'b0, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_ADD, dp_pkg::FWD_ALT, 1'b0, 1'b0, 1'b1, 1'b0, WB_ALU},
        '{32'h00000000, 32'h00000000, 1'b1, dp_pkg::SH_LSL, 5'd0,
          dp_pkg::ALU_ADD, dp_pkg::FWD_RF, 1'b1, 1'b0, 1'b1, 1'b0, WB_ALU}
    };

    logic               clk;
    logic               arst_n;
    dp_pkg::word_t      ram_data;
    logic               fwd_ram;
    dp_pkg::reg_addr_t  w_addr1;
    logic               w_en1;
    dp_pkg::reg_addr_t  w_addr2;
    logic               w_en2;
    dp_pkg::reg_addr_t  w_addr3;
    logic               w_en3;
    dp_pkg::word_t      w_data3;
    dp_pkg::reg_addr_t  a_addr;
    dp_pkg::reg_addr_t  b_addr;
    dp_pkg::reg_addr_t  shift_addr;
    dp_pkg::reg_addr_t  str_addr;
    dp_pkg::word_t      pc;
    dp_pkg::fwd_sel_e   sel_a_in;
    dp_pkg::fwd_sel_e   sel_b_in;
    dp_pkg::fwd_sel_e   sel_shift_in;
    logic               en_a;
    logic               en_b;
    logic               en_s;
    dp_pkg::word_t      shift_imm;
    logic               sel_shift;
    dp_pkg::shift_op_e  shift_op;
    logic               sel_a;
    logic               sel_b;
    logic               sel_post_shift;
    dp_pkg::word_t      imm_data;
    dp_pkg::alu_op_e    alu_op;
    logic               en_status;
    dp_pkg::word_t      datapath_out;
    dp_pkg::word_t      status_out;
    dp_pkg::word_t      str_data;

    row_t   rows [NROWS];
    integer seed = 32'h972;
    int     errors = 0;
    int     cycles = 0;

    datapath_top u_datapath_top (
        .clk            (clk),
        .arst_n         (arst_n),
        .ram_data       (ram_data),
        .fwd_ram        (fwd_ram),
        .w_addr1        (w_addr1),
        .w_en1          (w_en1),
        .w_addr2        (w_addr2),
        .w_en2          (w_en2),
        .w_addr3        (w_addr3),
        .w_en3          (w_en3),
        .w_data3        (w_data3),
        .a_addr         (a_addr),
        .b_addr         (b_addr),
        .shift_addr     (shift_addr),
        .str_addr       (str_addr),
        .pc             (pc),
        .sel_a_in       (sel_a_in),
        .sel_b_in       (sel_b_in),
        .sel_shift_in   (sel_shift_in),
        .en_a           (en_a),
        .en_b           (en_b),
        .en_s           (en_s),
        .shift_imm      (shift_imm),
        .sel_shift      (sel_shift),
        .shift_op       (shift_op),
        .sel_a          (sel_a),
        .sel_b          (sel_b),
        .sel_post_shift (sel_post_shift),
        .imm_data       (imm_data),
        .alu_op         (alu_op),
        .en_status      (en_status),
        .datapath_out   (datapath_out),
        .status_out     (status_out),
        .str_data       (str_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input dp_pkg::word_t got, input dp_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one bit position per step
    function automatic dp_pkg::word_t shift_model(input dp_pkg::word_t v,
                                                  input dp_pkg::shift_op_e op,
                                                  input logic [4:0] amt);
        dp_pkg::word_t r;
        int i;
        r = v;
        for (i = 0; i < int'(amt); i++) begin
            case (op)
                dp_pkg::SH_LSL: r = {r[30:0], 1'b0};
                dp_pkg::SH_LSR: r = {1'b0, r[31:1]};
                dp_pkg::SH_ASR: r = {r[31], r[31:1]};
                default:        r = {r[0], r[31:1]};
            endcase
        end
        return r;
    endfunction

    // overflow judged on the exact signed result
    function automatic void alu_model(input dp_pkg::alu_op_e op, input dp_pkg::word_t a,
                                      input dp_pkg::word_t b, output dp_pkg::word_t res,
                                      output dp_pkg::word_t flg);
        longint sa;
        longint sb;
        longint sres;
        logic   c;
        logic   v;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        sres = 0;
        c = 1'b0;
        case (op)
            dp_pkg::ALU_ADD: begin
                res = a + b;
                c = (a + b) < a;
                sres = sa + sb;
            end
            dp_pkg::ALU_SUB: begin
                res = a - b;
                c = a >= b;
                sres = sa - sb;
            end
            dp_pkg::ALU_RSB: begin
                res = b - a;
                c = b >= a;
                sres = sb - sa;
            end
            dp_pkg::ALU_AND: res = a & b;
            dp_pkg::ALU_ORR: res = a | b;
            dp_pkg::ALU_EOR: res = a ^ b;
            dp_pkg::ALU_MOV: res = b;
            default:         res = ~b;
        endcase
        v = (sres > 64'sd2147483647) || (sres < -64'sd2147483648);
        flg = {res[31], res == 32'h0, c, v, 28'h0};
    endfunction

    task automatic check_reset();
        int i;
        @(negedge clk);
        check("status_out", status_out, 32'h0);
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            str_addr <= dp_pkg::reg_addr_t'(i);
            @(negedge clk);
            check("str_data", str_data, 32'h0);
        end
    endtask

    task automatic run_row(input int idx);
        row_t              r;
        dp_pkg::word_t     amt_w, imm, ram, pc_val, w3_val;
        dp_pkg::word_t     exp_a, shifted, vb_in, vb, va, res, flg, exp_wb;
        dp_pkg::reg_addr_t dest;
        r = rows[idx];
        amt_w = {27'h0, r.amt};
        imm = r.a ^ 32'h5A5A_0F0F;
        ram = ~r.b;
        pc_val = 32'h0000_1000 + dp_pkg::word_t'(idx * 4);
        w3_val = 32'hC0DE_0000 | dp_pkg::word_t'(idx);

        case (r.fwd_a)
            dp_pkg::FWD_ALU: exp_a = r.b;
            dp_pkg::FWD_ALT: exp_a = pc_val;
            default:         exp_a = r.a;
        endcase
        shifted = shift_model(r.b, r.shop, r.amt);
        vb_in = r.sel_b ? imm : shifted;
        vb = r.post ? r.b : vb_in;
        va = r.sel_a ? 32'h0 : exp_a;
        alu_model(r.op, va, vb, res, flg);
        // each write-back kind has its own register, r4 upwards
        dest = 4'd4 + dp_pkg::reg_addr_t'(r.wb);
        case (r.wb)
            WB_ALU:  exp_wb = res;
            WB_RAM:  exp_wb = ram;
            WB_ALL3: exp_wb = w3_val;
            default: exp_wb = vb_in;
        endcase

        // operands to r1 and r2, then the register shift amount to r3
        @(posedge clk);
        w_en3 <= 1'b1;
        w_addr3 <= 4'd1;
        w_data3 <= r.a;
        @(posedge clk);
        w_addr3 <= 4'd2;
        w_data3 <= r.b;
        @(posedge clk);
        w_addr3 <= 4'd3;
        w_data3 <= r.rf_sh ? amt_w : amt_w + 32'd7;
        b_addr <= 4'd2;
        sel_b_in <= dp_pkg::FWD_RF;
        en_b <= 1'b1;
        alu_op <= dp_pkg::ALU_MOV;
        sel_a <= 1'b0;
        sel_b <= 1'b0;
        sel_post_shift <= 1'b1;
        // alu now passes B, which is what FWD_ALU hands to A
        @(posedge clk);
        w_en3 <= 1'b0;
        en_a <= 1'b1;
        en_s <= 1'b1;
        a_addr <= 4'd1;
        shift_addr <= 4'd3;
        sel_a_in <= r.fwd_a;
        sel_shift_in <= dp_pkg::FWD_RF;
        sel_shift <= r.rf_sh;
        shift_imm <= r.rf_sh ? amt_w + 32'd7 : amt_w;
        pc <= pc_val;
        @(posedge clk);
        en_a <= 1'b0;
        en_b <= 1'b0;
        en_s <= 1'b0;
        shift_op <= r.shop;
        alu_op <= r.op;
        sel_a <= r.sel_a;
        sel_b <= r.sel_b;
        sel_post_shift <= r.post;
        imm_data <= imm;
        ram_data <= ram;
        en_status <= 1'b1;
        @(negedge clk);
        check("datapath_out", datapath_out, res);
        @(posedge clk);
        en_status <= 1'b0;
        // different flags on the alu while the status register must hold
        alu_op <= (r.op == dp_pkg::ALU_MVN) ? dp_pkg::ALU_MOV : dp_pkg::ALU_MVN;
        @(negedge clk);
        check("status_out", status_out, flg);
        @(posedge clk);
        alu_op <= r.op;
        w_addr1 <= dest;
        w_addr2 <= dest;
        w_addr3 <= dest;
        w_data3 <= w3_val;
        w_en1 <= (r.wb != WB_VALB);
        w_en2 <= (r.wb == WB_VALB) || (r.wb == WB_ALL3) || (r.wb == WB_P21);
        w_en3 <= (r.wb == WB_ALL3);
        fwd_ram <= (r.wb == WB_RAM);
        @(negedge clk);
        check("status_out", status_out, flg);
        @(posedge clk);
        w_en1 <= 1'b0;
        w_en2 <= 1'b0;
        w_en3 <= 1'b0;
        fwd_ram <= 1'b0;
        str_addr <= dest;
        @(negedge clk);
        check("str_data", str_data, exp_wb);
    endtask

    initial begin
        int i;
        arst_n <= 1'b0;
        ram_data <= '0;
        fwd_ram <= 1'b0;
        w_addr1 <= '0;
        w_en1 <= 1'b0;
        w_addr2 <= '0;
        w_en2 <= 1'b0;
        w_addr3 <= '0;
        w_en3 <= 1'b0;
        w_data3 <= '0;
        a_addr <= '0;
        b_addr <= '0;
        shift_addr <= '0;
        str_addr <= '0;
        pc <= '0;
        sel_a_in <= dp_pkg::FWD_RF;
        sel_b_in <= dp_pkg::FWD_RF;
        sel_shift_in <= dp_pkg::FWD_RF;
        en_a <= 1'b0;
        en_b <= 1'b0;
        en_s <= 1'b0;
        shift_imm <= '0;
        sel_shift <= 1'b0;
        shift_op <= dp_pkg::SH_LSL;
        sel_a <= 1'b0;
        sel_b <= 1'b0;
        sel_post_shift <= 1'b0;
        imm_data <= '0;
        alu_op <= dp_pkg::ALU_ADD;
        en_status <= 1'b0;

        for (i = 0; i < NROWS; i++) begin
            rows[i] = ROWS[i];
            if (ROWS[i].rnd) begin
                rows[i].a = $random(seed);
                rows[i].b = $random(seed);
            end
        end

        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        check_reset();
        for (i = 0; i < NROWS; i++) begin
            run_row(i);
        end

        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_datapath

`default_nettype wire

// File: vlog.f
dp_pkg.sv
rf_read_if.sv
regfile.sv
barrel_shifter.sv
alu.sv
datapath.sv
datapath_top.sv
tb_datapath.sv
